// File: hw/exu_consts.svh
// Widths are fixed for RV32; the ALU leading-zero counter assumes a 32-bit data path
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

//////////////////////////////
// Data path
//////////////////////////////

// Integer register width
`define EXU_XLEN 32

// Register file address width
`define EXU_RF_AW 5

//////////////////////////////
// Units and pipeline
//////////////////////////////

// One multiplier bit per iteration
`define EXU_MUL_CYCLES 32

// Value of the pc field in EX/WB out of reset
`define EXU_PC_RESET 32'h0000_0000

`endif

// File: hw/exu_pkg.sv
// Types only for the execute stage; widths come from exu_consts.svh and need RV32 values
`include "exu_consts.svh"

package exu_pkg;

  // ALU operations, compares and branch conditions share one encoding
  typedef enum logic [4:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    CLZ,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_op_e;

  // Multiply operations from the M extension
  typedef enum logic [1:0] {
    MUL,
    MULH,
    MULHSU,
    MULHU
  } mul_op_e;

  // Divide and remainder operations
  typedef enum logic [1:0] {
    DIV,
    DIVU,
    REM,
    REMU
  } div_op_e;

  // Decoded instruction handed over from ID
  typedef struct packed {
    logic                  instr_valid;
    logic                  alu_en;
    logic                  mul_en;
    logic                  div_en;
    alu_op_e               alu_op;
    mul_op_e               mul_op;
    div_op_e               div_op;
    logic [`EXU_XLEN-1:0]  operand_a;
    logic [`EXU_XLEN-1:0]  operand_b;
    // Branch target, already computed in ID
    logic [`EXU_XLEN-1:0]  operand_c;
    logic                  rf_we;
    logic [`EXU_RF_AW-1:0] rf_waddr;
    logic [`EXU_XLEN-1:0]  pc;
  } id_ex_pipe_t;

  // Entry handed to write-back
  typedef struct packed {
    logic                  instr_valid;
    logic                  rf_we;
    logic [`EXU_RF_AW-1:0] rf_waddr;
    logic [`EXU_XLEN-1:0]  rf_wdata;
    logic [`EXU_XLEN-1:0]  pc;
    logic                  branch_taken;
  } ex_wb_pipe_t;

  // Controller levels towards EX
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_fsm_t;

endpackage

// File: hw/exu_alu.sv
// Purely combinational; the leading-zero counter is lent to the divider while div_clz_en_i is high
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_alu import exu_pkg::*; (
  input  alu_op_e              operator_i,
  input  logic [`EXU_XLEN-1:0] operand_a_i,
  input  logic [`EXU_XLEN-1:0] operand_b_i,
  input  logic                 div_clz_en_i,
  input  logic [`EXU_XLEN-1:0] div_clz_data_i,
  output logic [`EXU_XLEN-1:0] result_o,
  output logic                 cmp_result_o,
  output logic [5:0]           div_clz_result_o
);

  logic [`EXU_XLEN-1:0] clz_in;
  logic [5:0]           clz_cnt;
  logic                 cmp_signed;
  logic [`EXU_XLEN:0]   cmp_diff;
  logic                 cmp_lt;
  logic                 cmp_eq;
  logic [4:0]           shamt;

  // Shared comparator
  // One extra bit holds the sign of the difference for both signed and unsigned
  assign cmp_signed = (operator_i == SLT) || (operator_i == LT) || (operator_i == GE);
  assign cmp_diff   = {cmp_signed & operand_a_i[`EXU_XLEN-1], operand_a_i} -
                      {cmp_signed & operand_b_i[`EXU_XLEN-1], operand_b_i};
  assign cmp_lt     = cmp_diff[`EXU_XLEN];
  assign cmp_eq     = (operand_a_i == operand_b_i);

  always_comb begin
    unique case (operator_i)
      EQ:       cmp_result_o = cmp_eq;
      NE:       cmp_result_o = !cmp_eq;
      LT, LTU:  cmp_result_o = cmp_lt;
      GE, GEU:  cmp_result_o = !cmp_lt;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  // Leading zeros, divider request wins
  assign clz_in = div_clz_en_i ? div_clz_data_i : operand_a_i;

  always_comb begin
    clz_cnt = 6'd`EXU_XLEN;
    // Later hits are higher bits, so the top set bit decides
    for (int i = 0; i < `EXU_XLEN; i++) begin
      if (clz_in[i]) begin
        clz_cnt = 6'(`EXU_XLEN - 1 - i);
      end
    end
  end

  assign div_clz_result_o = clz_cnt;

  // Shift amount is the low five bits as in RV32
  assign shamt = operand_b_i[4:0];

  always_comb begin
    unique case (operator_i)
      ADD:                   result_o = operand_a_i + operand_b_i;
      SUB:                   result_o = operand_a_i - operand_b_i;
      AND:                   result_o = operand_a_i & operand_b_i;
      OR:                    result_o = operand_a_i | operand_b_i;
      XOR:                   result_o = operand_a_i ^ operand_b_i;
      SLL:                   result_o = operand_a_i << shamt;
      SRL:                   result_o = operand_a_i >> shamt;
      SRA:                   result_o = $unsigned($signed(operand_a_i) >>> shamt);
      SLT, SLTU:             result_o = {{(`EXU_XLEN-1){1'b0}}, cmp_lt};
      CLZ:                   result_o = {{(`EXU_XLEN-6){1'b0}}, clz_cnt};
      EQ, NE, LT, GE, LTU, GEU: result_o = {{(`EXU_XLEN-1){1'b0}}, cmp_result_o};
      default:               result_o = '0;
    endcase
  end

endmodule

// File: hw/exu_mult.sv
// Fixed latency of EXU_MUL_CYCLES + 1; operands must stay stable from valid_i until the result is taken
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_mult import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mul_op_e              operator_i,
  input  logic [`EXU_XLEN-1:0] op_a_i,
  input  logic [`EXU_XLEN-1:0] op_b_i,
  input  logic                 valid_i,
  input  logic                 ready_i,
  output logic [`EXU_XLEN-1:0] result_o,
  output logic                 ready_o,
  output logic                 valid_o
);

  typedef enum logic [1:0] {MUL_IDLE, MUL_BUSY, MUL_DONE} mul_state_e;

  mul_state_e                       state_q;
  logic [$clog2(`EXU_MUL_CYCLES):0] cnt_q;
  logic                             a_signed;
  logic                             b_signed;
  logic [`EXU_XLEN-1:0]             a_mag;
  logic [`EXU_XLEN-1:0]             b_mag;
  logic [2*`EXU_XLEN-1:0]           mcand_q;
  logic [2*`EXU_XLEN-1:0]           acc_q;
  logic [2*`EXU_XLEN-1:0]           prod;
  logic [`EXU_XLEN-1:0]             mplier_q;
  logic                             neg_q;
  mul_op_e                          op_q;

  // Operand a is signed except for MULHU, b only for MUL and MULH
  assign a_signed = (operator_i != MULHU) && op_a_i[`EXU_XLEN-1];
  assign b_signed = ((operator_i == MUL) || (operator_i == MULH)) && op_b_i[`EXU_XLEN-1];
  assign a_mag    = a_signed ? -op_a_i : op_a_i;
  assign b_mag    = b_signed ? -op_b_i : op_b_i;

  // Control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        MUL_IDLE: begin
          cnt_q <= '0;
          if (valid_i) begin
            state_q <= MUL_BUSY;
          end
        end
        MUL_BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (!valid_i) begin
            state_q <= MUL_IDLE;
          end else if (cnt_q == `EXU_MUL_CYCLES - 1) begin
            state_q <= MUL_DONE;
          end
        end
        default: begin
          // Leave on acceptance or when the instruction is dropped
          if (!valid_i || ready_i) begin
            state_q <= MUL_IDLE;
          end
        end
      endcase
    end
  end

  // Shift-add datapath
  always_ff @(posedge clk) begin
    if ((state_q == MUL_IDLE) && valid_i) begin
      mcand_q  <= {{`EXU_XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      neg_q    <= a_signed ^ b_signed;
      op_q     <= operator_i;
    end else if (state_q == MUL_BUSY) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Sign fix on the finished magnitude product
  assign prod     = neg_q ? -acc_q : acc_q;
  assign result_o = (op_q == MUL) ? prod[`EXU_XLEN-1:0] : prod[2*`EXU_XLEN-1:`EXU_XLEN];

  assign valid_o = (state_q == MUL_DONE);
  assign ready_o = ((state_q == MUL_IDLE) && !valid_i) || ((state_q == MUL_DONE) && ready_i);

  // Result must not move while write-back stalls
  a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> $stable(result_o));

endmodule

// File: hw/exu_div.sv
// Latency 2 to 34 cycles by dividend leading zeros; needs the ALU CLZ in the same cycle as the start
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_div import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  div_op_e              operator_i,
  input  logic [`EXU_XLEN-1:0] op_a_i,
  input  logic [`EXU_XLEN-1:0] op_b_i,
  input  logic [5:0]           div_clz_result_i,
  input  logic                 valid_i,
  input  logic                 ready_i,
  output logic                 div_clz_en_o,
  output logic [`EXU_XLEN-1:0] div_clz_data_o,
  output logic [`EXU_XLEN-1:0] result_o,
  output logic                 ready_o,
  output logic                 valid_o
);

  typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_FIX, DIV_DONE} div_state_e;

  div_state_e           state_q;
  logic [5:0]           cnt_q;
  logic                 start;
  logic                 op_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [`EXU_XLEN-1:0] a_mag;
  logic [`EXU_XLEN-1:0] b_mag;
  logic                 div_zero;
  logic                 div_ovf;
  div_op_e              op_q;
  logic [`EXU_XLEN-1:0] bmag_q;
  logic [`EXU_XLEN-1:0] dvd_q;
  logic [`EXU_XLEN-1:0] rem_q;
  logic                 qneg_q;
  logic                 rneg_q;
  logic [`EXU_XLEN:0]   rem_shift;
  logic [`EXU_XLEN:0]   rem_diff;
  logic                 rem_ge;
  logic [`EXU_XLEN-1:0] res_q;

  assign start     = (state_q == DIV_IDLE) && valid_i;
  assign op_signed = (operator_i == DIV) || (operator_i == REM);
  assign a_neg     = op_signed && op_a_i[`EXU_XLEN-1];
  assign b_neg     = op_signed && op_b_i[`EXU_XLEN-1];
  assign a_mag     = a_neg ? -op_a_i : op_a_i;
  assign b_mag     = b_neg ? -op_b_i : op_b_i;

  // RISC-V corner cases bypass the iterations
  assign div_zero = (op_b_i == '0);
  assign div_ovf  = op_signed && (op_a_i == {1'b1, {(`EXU_XLEN-1){1'b0}}}) && (op_b_i == '1);

  // Dividend magnitude goes to the ALU counter at start
  assign div_clz_en_o   = start;
  assign div_clz_data_o = a_mag;

  // One restoring step
  assign rem_shift = {rem_q, dvd_q[`EXU_XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, bmag_q};
  assign rem_ge    = (rem_shift >= {1'b0, bmag_q});

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        DIV_IDLE: begin
          // Remaining bits after the leading-zero skip
          cnt_q <= 6'd`EXU_XLEN - div_clz_result_i;
          if (valid_i) begin
            if (div_zero || div_ovf || (div_clz_result_i == 6'd`EXU_XLEN)) begin
              state_q <= DIV_FIX;
            end else begin
              state_q <= DIV_BUSY;
            end
          end
        end
        DIV_BUSY: begin
          cnt_q <= cnt_q - 1'b1;
          if (!valid_i) begin
            state_q <= DIV_IDLE;
          end else if (cnt_q == 6'd1) begin
            state_q <= DIV_FIX;
          end
        end
        DIV_FIX: begin
          state_q <= valid_i ? DIV_DONE : DIV_IDLE;
        end
        default: begin
          if (!valid_i || ready_i) begin
            state_q <= DIV_IDLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      op_q   <= operator_i;
      bmag_q <= b_mag;
      if (div_zero) begin
        // Quotient all ones, remainder is the dividend
        dvd_q  <= '1;
        rem_q  <= op_a_i;
        qneg_q <= 1'b0;
        rneg_q <= 1'b0;
      end else if (div_ovf) begin
        dvd_q  <= op_a_i;
        rem_q  <= '0;
        qneg_q <= 1'b0;
        rneg_q <= 1'b0;
      end else begin
        dvd_q  <= a_mag << div_clz_result_i;
        rem_q  <= '0;
        qneg_q <= a_neg ^ b_neg;
        rneg_q <= a_neg;
      end
    end else if (state_q == DIV_BUSY) begin
      // Quotient bits enter from the bottom as dividend bits leave the top
      rem_q <= rem_ge ? rem_diff[`EXU_XLEN-1:0] : rem_shift[`EXU_XLEN-1:0];
      dvd_q <= {dvd_q[`EXU_XLEN-2:0], rem_ge};
    end else if (state_q == DIV_FIX) begin
      if ((op_q == DIV) || (op_q == DIVU)) begin
        res_q <= qneg_q ? -dvd_q : dvd_q;
      end else begin
        res_q <= rneg_q ? -rem_q : rem_q;
      end
    end
  end

  assign result_o = res_q;
  assign valid_o  = (state_q == DIV_DONE);
  assign ready_o  = ((state_q == DIV_IDLE) && !valid_i) || ((state_q == DIV_DONE) && ready_i);

  // Quotient of a divide by zero is all ones whatever the signs
  a_div_zero_quot: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && (bmag_q == '0) && ((op_q == DIV) || (op_q == DIVU)) |-> (result_o == '1));

endmodule

// File: hw/exu_ex_stage.sv
// No LSU, CSR or exception path; upstream must hold id_ex_pipe_i until ex_ready_o is seen high
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_ex_stage import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  id_ex_pipe_t          id_ex_pipe_i,
  input  ctrl_fsm_t            ctrl_fsm_i,
  input  logic                 wb_ready_i,
  output ex_wb_pipe_t          ex_wb_pipe_o,
  output logic [`EXU_XLEN-1:0] rf_wdata_o,
  output logic                 branch_decision_o,
  output logic [`EXU_XLEN-1:0] branch_target_o,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  logic                 instr_valid;
  logic                 mul_en_gated;
  logic                 div_en_gated;
  logic [`EXU_XLEN-1:0] alu_result;
  logic                 alu_cmp_result;
  logic [`EXU_XLEN-1:0] mul_result;
  logic                 mul_ready;
  logic                 mul_valid;
  logic [`EXU_XLEN-1:0] div_result;
  logic                 div_ready;
  logic                 div_valid;
  logic                 div_clz_en;
  logic [`EXU_XLEN-1:0] div_clz_data;
  logic [5:0]           div_clz_result;

  // Kill and halt both drop the instruction for this cycle
  assign instr_valid  = id_ex_pipe_i.instr_valid && !ctrl_fsm_i.kill_ex && !ctrl_fsm_i.halt_ex;
  assign mul_en_gated = id_ex_pipe_i.mul_en && instr_valid;
  assign div_en_gated = id_ex_pipe_i.div_en && instr_valid;

  //////////////////////////////
  // Units
  //////////////////////////////

  exu_alu u_alu (
    .operator_i       (id_ex_pipe_i.alu_op),
    .operand_a_i      (id_ex_pipe_i.operand_a),
    .operand_b_i      (id_ex_pipe_i.operand_b),
    .div_clz_en_i     (div_clz_en),
    .div_clz_data_i   (div_clz_data),
    .result_o         (alu_result),
    .cmp_result_o     (alu_cmp_result),
    .div_clz_result_o (div_clz_result)
  );

  exu_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (id_ex_pipe_i.mul_op),
    .op_a_i     (id_ex_pipe_i.operand_a),
    .op_b_i     (id_ex_pipe_i.operand_b),
    .valid_i    (mul_en_gated),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid)
  );

  // Divider borrows the ALU leading-zero counter
  exu_div u_div (
    .clk              (clk),
    .rst_n            (rst_n),
    .operator_i       (id_ex_pipe_i.div_op),
    .op_a_i           (id_ex_pipe_i.operand_a),
    .op_b_i           (id_ex_pipe_i.operand_b),
    .div_clz_result_i (div_clz_result),
    .valid_i          (div_en_gated),
    .ready_i          (wb_ready_i),
    .div_clz_en_o     (div_clz_en),
    .div_clz_data_o   (div_clz_data),
    .result_o         (div_result),
    .ready_o          (div_ready),
    .valid_o          (div_valid)
  );

  // Result mux by enable, ALU when nothing else claims it
  always_comb begin
    if (id_ex_pipe_i.mul_en) begin
      rf_wdata_o = mul_result;
    end else if (id_ex_pipe_i.div_en) begin
      rf_wdata_o = div_result;
    end else begin
      rf_wdata_o = alu_result;
    end
  end

  assign branch_decision_o = alu_cmp_result;
  assign branch_target_o   = id_ex_pipe_i.operand_c;

  // Stage handshake
  assign ex_ready_o = ctrl_fsm_i.kill_ex ||
                      (wb_ready_i && mul_ready && div_ready && !ctrl_fsm_i.halt_ex);
  assign ex_valid_o = instr_valid && (id_ex_pipe_i.alu_en ||
                                      (id_ex_pipe_i.mul_en && mul_valid) ||
                                      (id_ex_pipe_i.div_en && div_valid));

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_pipe_o.instr_valid  <= 1'b0;
      ex_wb_pipe_o.rf_we        <= 1'b0;
      ex_wb_pipe_o.rf_waddr     <= '0;
      ex_wb_pipe_o.rf_wdata     <= '0;
      ex_wb_pipe_o.pc           <= `EXU_PC_RESET;
      ex_wb_pipe_o.branch_taken <= 1'b0;
    end else if (ex_valid_o && wb_ready_i) begin
      ex_wb_pipe_o.instr_valid  <= 1'b1;
      ex_wb_pipe_o.rf_we        <= id_ex_pipe_i.rf_we;
      ex_wb_pipe_o.rf_waddr     <= id_ex_pipe_i.rf_waddr;
      ex_wb_pipe_o.rf_wdata     <= rf_wdata_o;
      ex_wb_pipe_o.pc           <= id_ex_pipe_i.pc;
      ex_wb_pipe_o.branch_taken <= id_ex_pipe_i.alu_en && alu_cmp_result;
    end else if (wb_ready_i) begin
      // Nothing ready this cycle, pass a bubble
      ex_wb_pipe_o.instr_valid <= 1'b0;
    end
  end

  // Decoder selects at most one unit
  a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex_pipe_i.instr_valid |->
      $onehot0({id_ex_pipe_i.alu_en, id_ex_pipe_i.mul_en, id_ex_pipe_i.div_en}));

  // A live instruction is never accepted without its result
  a_no_lost_instr: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && ex_ready_o &&
      (id_ex_pipe_i.alu_en || id_ex_pipe_i.mul_en || id_ex_pipe_i.div_en) |-> ex_valid_o);

endmodule

// File: verif/exu_tb.sv
// Plays ID, controller and write-back around the EX stage; expects exu_consts.svh on the include path
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_tb import exu_pkg::*; ();

  localparam logic [1:0] U_ALU      = 2'd0;
  localparam logic [1:0] U_MUL      = 2'd1;
  localparam logic [1:0] U_DIV      = 2'd2;
  localparam int         LIMIT      = 200;
  localparam int         KILL_AFTER = 4;

  // One stimulus row with its expected write-back
  typedef struct packed {
    logic [1:0]           unit;
    logic [4:0]           op;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    logic                 kill;
    logic [`EXU_XLEN-1:0] exp_wdata;
    logic                 exp_taken;
  } stim_row_t;

  logic                 clk;
  logic                 rst_n;
  id_ex_pipe_t          id_ex_pipe_i;
  ctrl_fsm_t            ctrl_fsm_i;
  logic                 wb_ready_i;
  ex_wb_pipe_t          ex_wb_pipe_o;
  logic [`EXU_XLEN-1:0] rf_wdata_o;
  logic                 branch_decision_o;
  logic [`EXU_XLEN-1:0] branch_target_o;
  logic                 ex_ready_o;
  logic                 ex_valid_o;

  stim_row_t   rows[$];
  ex_wb_pipe_t exp_q[$];
  ex_wb_pipe_t mon_exp;
  ex_wb_pipe_t held_q;
  logic        hold_q   = 1'b0;
  logic [31:0] lfsr_q;
  int          checks   = 0;
  int          errors   = 0;
  int          pushed   = 0;
  int          wb_count = 0;

  exu_ex_stage u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe_i),
    .ctrl_fsm_i        (ctrl_fsm_i),
    .wb_ready_i        (wb_ready_i),
    .ex_wb_pipe_o      (ex_wb_pipe_o),
    .rf_wdata_o        (rf_wdata_o),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Right-shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [71:0] actual,
                             input logic [71:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout: no progress after %0d cycles waiting for %s", LIMIT, what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic add_row(input logic [1:0] unit, input logic [4:0] op,
                         input logic [31:0] a, input logic [31:0] b, input logic kill,
                         input logic [31:0] exp_wdata, input logic exp_taken);
    rows.push_back('{unit, op, a, b, kill, exp_wdata, exp_taken});
  endtask

  // Next edge, then inputs settle 5 ns later; write-back stalls on about a quarter of cycles
  task automatic next_cycle();
    logic [31:0] bits;
    @(posedge clk);
    #5;
    random_bits(2, bits);
    wb_ready_i = (bits[1:0] != 2'b11);
  endtask

  //////////////////////////////
  // Driver
  //////////////////////////////

  // Holds the instruction until a transfer edge; kill rows are dropped while the unit is busy
  task automatic drive_row(input stim_row_t r, input int idx);
    ex_wb_pipe_t exp_e;
    int          waited;
    logic        done;
    id_ex_pipe_i             = '0;
    id_ex_pipe_i.instr_valid = 1'b1;
    id_ex_pipe_i.alu_en      = (r.unit == U_ALU);
    id_ex_pipe_i.mul_en      = (r.unit == U_MUL);
    id_ex_pipe_i.div_en      = (r.unit == U_DIV);
    id_ex_pipe_i.alu_op      = (r.unit == U_ALU) ? alu_op_e'(r.op) : ADD;
    id_ex_pipe_i.mul_op      = mul_op_e'(r.op[1:0]);
    id_ex_pipe_i.div_op      = div_op_e'(r.op[1:0]);
    id_ex_pipe_i.operand_a   = r.a;
    id_ex_pipe_i.operand_b   = r.b;
    id_ex_pipe_i.operand_c   = 32'h0000_4000 + 32'(idx * 4);
    id_ex_pipe_i.rf_we       = 1'b1;
    id_ex_pipe_i.rf_waddr    = 5'(idx);
    id_ex_pipe_i.pc          = 32'(idx * 4);
    if (!r.kill) begin
      exp_e              = '0;
      exp_e.instr_valid  = 1'b1;
      exp_e.rf_we        = 1'b1;
      exp_e.rf_waddr     = 5'(idx);
      exp_e.rf_wdata     = r.exp_wdata;
      exp_e.pc           = 32'(idx * 4);
      exp_e.branch_taken = r.exp_taken;
      exp_q.push_back(exp_e);
      pushed++;
    end
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      // Branch outputs are combinational from the presented instruction
      if ((waited == 0) && (r.unit == U_ALU)) begin
        check_value("branch_decision_o", branch_decision_o, r.exp_taken);
        check_value("branch_target_o", branch_target_o, id_ex_pipe_i.operand_c);
      end
      if (ex_ready_o) begin
        done = 1'b1;
        // A live instruction leaves with its result on the forwarding path
        if (!r.kill) begin
          check_value("ex_valid_o", ex_valid_o, 1'b1);
          check_value("rf_wdata_o", rf_wdata_o, r.exp_wdata);
        end
      end else begin
        if (waited == LIMIT) abort_on_timeout("ex_ready_o");
        next_cycle();
        waited++;
        if (r.kill && (waited == KILL_AFTER)) begin
          ctrl_fsm_i.kill_ex = 1'b1;
        end
      end
    end
    // Transfer edge
    next_cycle();
    ctrl_fsm_i.kill_ex       = 1'b0;
    id_ex_pipe_i.instr_valid = 1'b0;
  endtask

  task automatic drain_queue();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == LIMIT) abort_on_timeout("write-back to drain");
      next_cycle();
      waited++;
    end
  endtask

  task automatic run_group(input string name, input int first, input int last);
    int err_start;
    err_start = errors;
    for (int i = first; i < last; i++) begin
      drive_row(rows[i], i);
    end
    drain_queue();
    $display("test %s: %0d instructions, %0d errors", name, last - first, errors - err_start);
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // Sampled mid-cycle, the following edge consumes when instr_valid and wb_ready_i are high
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_q) begin
        check_value("ex_wb_pipe_o while stalled", ex_wb_pipe_o, held_q);
      end
      hold_q = ex_wb_pipe_o.instr_valid && !wb_ready_i;
      held_q = ex_wb_pipe_o;
      if (ex_wb_pipe_o.instr_valid && wb_ready_i) begin
        wb_count++;
        if (exp_q.size() == 0) begin
          $display("Write-back entry at %0t ns arrived with no instruction outstanding", $time);
          errors++;
        end else begin
          mon_exp = exp_q.pop_front();
          check_value("ex_wb_pipe_o.pc", ex_wb_pipe_o.pc, mon_exp.pc);
          check_value("ex_wb_pipe_o.rf_waddr", ex_wb_pipe_o.rf_waddr, mon_exp.rf_waddr);
          check_value("ex_wb_pipe_o.rf_we", ex_wb_pipe_o.rf_we, mon_exp.rf_we);
          check_value("ex_wb_pipe_o.rf_wdata", ex_wb_pipe_o.rf_wdata, mon_exp.rf_wdata);
          check_value("ex_wb_pipe_o.branch_taken", ex_wb_pipe_o.branch_taken,
                      mon_exp.branch_taken);
        end
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    logic [31:0] sel;
    logic [31:0] ra;
    logic [31:0] rb;
    int          end_alu;
    int          end_mul;
    int          end_div;
    int          end_kill;
    lfsr_q       = 32'd90875;
    rst_n        = 1'b0;
    wb_ready_i   = 1'b1;
    ctrl_fsm_i   = '0;
    id_ex_pipe_i = '0;

    // ALU ops and branch compares
    add_row(U_ALU, ADD,  32'h0000_0005, 32'h0000_0007, 1'b0, 32'h0000_000C, 1'b0);
    add_row(U_ALU, SUB,  32'h0000_0010, 32'h0000_0020, 1'b0, 32'hFFFF_FFF0, 1'b0);
    add_row(U_ALU, AND,  32'hF0F0_F0F0, 32'hFF00_FF00, 1'b0, 32'hF000_F000, 1'b0);
    add_row(U_ALU, OR,   32'hF0F0_0000, 32'h0000_0F0F, 1'b0, 32'hF0F0_0F0F, 1'b0);
    add_row(U_ALU, XOR,  32'hAAAA_5555, 32'hFFFF_0000, 1'b0, 32'h5555_5555, 1'b0);
    add_row(U_ALU, SLL,  32'h0000_0003, 32'h0000_0024, 1'b0, 32'h0000_0030, 1'b0);
    add_row(U_ALU, SRL,  32'h8000_0000, 32'h0000_0004, 1'b0, 32'h0800_0000, 1'b0);
    add_row(U_ALU, SRA,  32'h8000_0000, 32'h0000_0004, 1'b0, 32'hF800_0000, 1'b0);
    add_row(U_ALU, SLT,  32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 32'h0000_0001, 1'b0);
    add_row(U_ALU, SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 32'h0000_0000, 1'b0);
    add_row(U_ALU, CLZ,  32'h0001_0000, 32'h0000_0000, 1'b0, 32'h0000_000F, 1'b0);
    add_row(U_ALU, CLZ,  32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0020, 1'b0);
    add_row(U_ALU, EQ,   32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0000_0001, 1'b1);
    add_row(U_ALU, NE,   32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0000_0000, 1'b0);
    add_row(U_ALU, LT,   32'hFFFF_FFFE, 32'h0000_0003, 1'b0, 32'h0000_0001, 1'b1);
    add_row(U_ALU, GE,   32'hFFFF_FFFE, 32'h0000_0003, 1'b0, 32'h0000_0000, 1'b0);
    add_row(U_ALU, LTU,  32'hFFFF_FFFE, 32'h0000_0003, 1'b0, 32'h0000_0000, 1'b0);
    add_row(U_ALU, GEU,  32'hFFFF_FFFE, 32'h0000_0003, 1'b0, 32'h0000_0001, 1'b1);
    end_alu = rows.size();

    // Low and high halves, all sign mixes
    add_row(U_MUL, MUL,    32'h0000_0007, 32'h0000_0006, 1'b0, 32'h0000_002A, 1'b0);
    add_row(U_MUL, MUL,    32'hFFFF_FFFD, 32'h0000_0005, 1'b0, 32'hFFFF_FFF1, 1'b0);
    add_row(U_MUL, MULH,   32'h8000_0000, 32'h8000_0000, 1'b0, 32'h4000_0000, 1'b0);
    add_row(U_MUL, MULH,   32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 32'hFFFF_FFFF, 1'b0);
    add_row(U_MUL, MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'hFFFF_FFFE, 1'b0);
    add_row(U_MUL, MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'hFFFF_FFFF, 1'b0);
    add_row(U_MUL, MULHSU, 32'h0000_0002, 32'h8000_0000, 1'b0, 32'h0000_0001, 1'b0);
    add_row(U_MUL, MULHU,  32'h8000_0000, 32'h0000_0004, 1'b0, 32'h0000_0002, 1'b0);
    end_mul = rows.size();

    // Quotients, remainders and RISC-V corner cases
    add_row(U_DIV, DIV,  32'h0000_0014, 32'h0000_0003, 1'b0, 32'h0000_0006, 1'b0);
    add_row(U_DIV, DIV,  32'hFFFF_FFEC, 32'h0000_0003, 1'b0, 32'hFFFF_FFFA, 1'b0);
    add_row(U_DIV, REM,  32'hFFFF_FFEC, 32'h0000_0003, 1'b0, 32'hFFFF_FFFE, 1'b0);
    add_row(U_DIV, DIV,  32'h0000_0007, 32'hFFFF_FFFE, 1'b0, 32'hFFFF_FFFD, 1'b0);
    add_row(U_DIV, REM,  32'h0000_0007, 32'hFFFF_FFFE, 1'b0, 32'h0000_0001, 1'b0);
    add_row(U_DIV, DIVU, 32'hFFFF_FFFF, 32'h0000_0010, 1'b0, 32'h0FFF_FFFF, 1'b0);
    add_row(U_DIV, REMU, 32'hFFFF_FFFF, 32'h0000_0010, 1'b0, 32'h0000_000F, 1'b0);
    add_row(U_DIV, DIVU, 32'h0000_0000, 32'h0000_0005, 1'b0, 32'h0000_0000, 1'b0);
    add_row(U_DIV, DIV,  32'h0000_1234, 32'h0000_0000, 1'b0, 32'hFFFF_FFFF, 1'b0);
    add_row(U_DIV, REM,  32'h0000_1234, 32'h0000_0000, 1'b0, 32'h0000_1234, 1'b0);
    add_row(U_DIV, DIVU, 32'h0000_0005, 32'h0000_0000, 1'b0, 32'hFFFF_FFFF, 1'b0);
    add_row(U_DIV, REMU, 32'h0000_0005, 32'h0000_0000, 1'b0, 32'h0000_0005, 1'b0);
    add_row(U_DIV, DIV,  32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 32'h8000_0000, 1'b0);
    add_row(U_DIV, REM,  32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 32'h0000_0000, 1'b0);
    end_div = rows.size();

    // Long divide killed mid-way, then the next instructions must still complete
    add_row(U_DIV, DIVU, 32'h7FFF_FFFF, 32'h0000_0003, 1'b1, 32'h0000_0000, 1'b0);
    add_row(U_ALU, ADD,  32'h0000_0100, 32'h0000_0023, 1'b0, 32'h0000_0123, 1'b0);
    add_row(U_DIV, DIV,  32'h0000_0064, 32'h0000_0007, 1'b0, 32'h0000_000E, 1'b0);
    end_kill = rows.size();

    // Random ALU rows, expected values from the op definitions
    for (int i = 0; i < 40; i++) begin
      random_bits(2, sel);
      random_bits(32, ra);
      random_bits(32, rb);
      case (sel[1:0])
        2'd1:    add_row(U_ALU, XOR, ra, rb, 1'b0, ra ^ rb, 1'b0);
        2'd2:    add_row(U_ALU, SLTU, ra, rb, 1'b0, {31'b0, ra < rb}, 1'b0);
        default: add_row(U_ALU, ADD, ra, rb, 1'b0, ra + rb, 1'b0);
      endcase
    end

    // Reset, released with the same 5 ns offset as the other inputs
    repeat (8) @(posedge clk);
    #5;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ex_wb_pipe_o.instr_valid", ex_wb_pipe_o.instr_valid, 1'b0);
    check_value("ex_valid_o", ex_valid_o, 1'b0);
    $display("test reset: %0d errors", errors);
    next_cycle();

    run_group("alu", 0, end_alu);
    run_group("mul", end_alu, end_mul);
    run_group("div", end_mul, end_div);
    run_group("kill", end_div, end_kill);
    run_group("random", end_kill, rows.size());

    if (wb_count != pushed) begin
      $display("Write-back saw %0d entries for %0d completed instructions", wb_count, pushed);
      errors++;
    end
    $display("Summary: %0d checks, %0d write-backs, %0d errors", checks, wb_count, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: exu.f
+incdir+hw
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_mult.sv
hw/exu_div.sv
hw/exu_ex_stage.sv
verif/exu_tb.sv

// File: Makefile
# Verilator build and run for the exu testbench
TOP := exu_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f exu.f

# Pass only when the simulation output holds the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
